// File: verilog/core_pkg.sv
`default_nettype none

package core_pkg;

    typedef logic [31:0]        word_t;     // Data, address or instruction
    typedef logic [3:0]         reg_idx_t;
    typedef logic signed [11:0] imm_t;

    // Operation codes, 4-bit field at 15:12
    typedef enum logic [3:0] {
        OP_OR    = 4'h0,
        OP_AND   = 4'h1,
        OP_ADD   = 4'h2,
        OP_MUL   = 4'h3,
        OP_RSV4  = 4'h4,
        OP_SHL   = 4'h5,
        OP_LT    = 4'h6,
        OP_EQ    = 4'h7,
        OP_GT    = 4'h8,
        OP_ANDN  = 4'h9,
        OP_XOR   = 4'hA,
        OP_SUB   = 4'hB,
        OP_XNOR  = 4'hC,
        OP_SHR   = 4'hD,
        OP_NE    = 4'hE,
        OP_RSV15 = 4'hF
    } op_t;

    typedef enum logic [1:0] {
        DEREF_REG       = 2'b00,    //  Z  <-  rhs
        DEREF_LOAD      = 2'b01,    //  Z  <- [rhs]
        DEREF_STORE_Z   = 2'b10,    // [Z] <-  rhs
        DEREF_STORE_RHS = 2'b11     // [rhs] <- Z
    } deref_t;

    typedef enum logic [1:0] {
        PH_DECODE = 2'd0,
        PH_EXEC   = 2'd1,
        PH_WRITE  = 2'd2
    } phase_t;

    localparam word_t    RESET_VECTOR = 32'h0000_0000;
    localparam reg_idx_t PC_INDEX     = 4'd15;
    localparam word_t    ILLEGAL_INSN = 32'hFFFF_FFFF;

endpackage

`default_nettype wire

// File: verilog/insn_fields_if.sv
`default_nettype none
`timescale 1ns/1ps

interface insn_fields_if
    import core_pkg::*;
();

    logic     kind;     // 0 means Y is the operand, 1 means imm is
    deref_t   deref;
    reg_idx_t z;
    reg_idx_t x;
    reg_idx_t y;
    op_t      op;
    imm_t     imm;
    logic     illegal;

    modport producer (output kind, deref, z, x, y, op, imm, illegal);
    modport consumer (input  kind, deref, z, x, y, op, imm, illegal);

endinterface

`default_nettype wire

// File: verilog/insn_decode.sv
`default_nettype none
`timescale 1ns/1ps

module insn_decode
    import core_pkg::*;
(
    input  word_t                  i_insn,
    insn_fields_if.producer        fields
);

    // Bit 31 only matters for the illegal check
    assign fields.kind  = i_insn[30];
    assign fields.deref = deref_t'(i_insn[29:28]);
    assign fields.z     = i_insn[27:24];
    assign fields.x     = i_insn[23:20];
    assign fields.y     = i_insn[19:16];
    assign fields.op    = op_t'(i_insn[15:12]);
    assign fields.imm   = i_insn[11:0];

    // All-ones word halts the core
    assign fields.illegal = (i_insn == ILLEGAL_INSN);

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`default_nettype none
`timescale 1ns/1ps

module reg_file
    import core_pkg::*;
(
    input  wire                    clk,
    input  wire                    reset_n,
    insn_fields_if.consumer        fields,
    input  word_t                  i_pc,
    input  wire                    i_we,
    input  word_t                  i_wdata,
    output word_t                  o_x_val,
    output word_t                  o_y_val,
    output word_t                  o_z_val
);

    word_t regs [1:14];     // r0 and r15 have no storage
    word_t pc_next;

    assign pc_next = i_pc + 32'd1;     // What r15 reads as

    function automatic word_t read_port(input reg_idx_t idx);
        word_t val;
        if (idx == 4'd0)
            val = '0;
        else if (idx == PC_INDEX)
            val = pc_next;
        else
            val = regs[idx];
        return val;
    endfunction

    assign o_x_val = read_port(fields.x);
    assign o_y_val = read_port(fields.y);
    assign o_z_val = read_port(fields.z);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 1; i <= 14; i++)
                regs[i] <= '0;
        end else if (i_we && fields.z != 4'd0 && fields.z != PC_INDEX) begin
            regs[fields.z] <= i_wdata;  // r15 writes are jumps, handled upstream
        end
    end

endmodule

`default_nettype wire

// File: verilog/exec_unit.sv
`default_nettype none
`timescale 1ns/1ps

module exec_unit
    import core_pkg::*;
(
    input  wire                    clk,
    input  wire                    reset_n,
    input  wire                    i_step,
    insn_fields_if.consumer        fields,
    input  word_t                  i_x_val,
    input  word_t                  i_y_val,
    output word_t                  o_rhs
);

    word_t imm_ext;
    word_t operand;
    word_t addend;
    word_t rhs_d;
    word_t rhs_q;
    logic  lt;
    logic  gt;
    logic  eq;

    assign imm_ext = {{20{fields.imm[11]}}, fields.imm};

    // Kind swaps the roles of Y and the immediate
    assign operand = fields.kind ? imm_ext : i_y_val;
    assign addend  = fields.kind ? i_y_val : imm_ext;

    // Signed compares
    assign lt = $signed(i_x_val) < $signed(operand);
    assign gt = $signed(i_x_val) > $signed(operand);
    assign eq = (i_x_val == operand);

    always_comb begin
        case (fields.op)
            OP_OR:   rhs_d = (i_x_val | operand) + addend;
            OP_AND:  rhs_d = (i_x_val & operand) + addend;
            OP_ADD:  rhs_d = (i_x_val + operand) + addend;
            OP_MUL:  rhs_d = (i_x_val * operand) + addend;
            OP_SHL:  rhs_d = (i_x_val << operand) + addend;
            OP_LT:   rhs_d = {32{lt}} + addend;        // True is minus one
            OP_EQ:   rhs_d = {32{eq}} + addend;
            OP_GT:   rhs_d = {32{gt}} + addend;
            OP_ANDN: rhs_d = (i_x_val & ~operand) + addend;
            OP_XOR:  rhs_d = (i_x_val ^ operand) + addend;
            OP_SUB:  rhs_d = (i_x_val - operand) + addend;
            OP_XNOR: rhs_d = (i_x_val ^ ~operand) + addend;
            OP_SHR:  rhs_d = (i_x_val >> operand) + addend;   // Logical
            OP_NE:   rhs_d = {32{~eq}} + addend;
            default: rhs_d = addend;                  // Reserved 4 and 15
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n)
            rhs_q <= '0;
        else if (i_step)
            rhs_q <= rhs_d;     // Held through WRITE
    end

    assign o_rhs = rhs_q;

endmodule

`default_nettype wire

// File: verilog/core_sequencer.sv
`default_nettype none
`timescale 1ns/1ps

module core_sequencer
    import core_pkg::*;
(
    input  wire                    clk,
    input  wire                    reset_n,
    input  wire                    i_en,
    insn_fields_if.consumer        fields,
    input  word_t                  i_rhs,
    input  word_t                  i_z_val,
    input  word_t                  i_mem_rdata,
    output word_t                  o_pc,
    output word_t                  o_mem_addr,
    output word_t                  o_mem_wdata,
    output word_t                  o_reg_wdata,
    output logic                   o_mem_we,
    output logic                   o_reg_we,
    output logic                   o_exec_step,
    output logic                   o_halt
);

    phase_t phase_q;
    phase_t phase_d;
    word_t  pc_q;
    word_t  wb_data;
    logic   halt_q;
    logic   advance;
    logic   in_decode;
    logic   in_write;
    logic   to_memory;
    logic   jump;

    // Nothing moves when disabled or halted
    assign advance   = i_en && !halt_q;
    assign in_decode = advance && (phase_q == PH_DECODE);
    assign in_write  = advance && (phase_q == PH_WRITE);

    always_comb begin
        case (phase_q)
            PH_DECODE: phase_d = PH_EXEC;
            PH_EXEC:   phase_d = PH_WRITE;
            default:   phase_d = PH_DECODE;
        endcase
    end

    // Modes 10 and 11 write memory, 00 and 01 write Z
    assign to_memory = fields.deref[1];
    assign jump      = !to_memory && (fields.z == PC_INDEX);

    // Mode 10 addresses by Z, everything else by the right-hand side
    assign o_mem_addr  = (fields.deref == DEREF_STORE_Z) ? i_z_val : i_rhs;
    assign o_mem_wdata = (fields.deref == DEREF_STORE_RHS) ? i_z_val : i_rhs;

    assign wb_data = (fields.deref == DEREF_LOAD) ? i_mem_rdata : i_rhs;

    assign o_mem_we    = in_write && to_memory;
    assign o_reg_we    = in_write && !to_memory;
    assign o_reg_wdata = wb_data;
    assign o_exec_step = advance && (phase_q == PH_EXEC);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            phase_q <= PH_DECODE;
            pc_q    <= RESET_VECTOR;
            halt_q  <= 1'b0;
        end else if (advance) begin
            if (in_decode && fields.illegal)
                halt_q <= 1'b1;     // Parks in DECODE until reset
            else
                phase_q <= phase_d;

            if (in_write)
                pc_q <= jump ? wb_data : pc_q + 32'd1;
        end
    end

    assign o_pc   = pc_q;
    assign o_halt = halt_q;

endmodule

`default_nettype wire

// File: verilog/core_top.sv
`default_nettype none
`timescale 1ns/1ps

module core_top
    import core_pkg::*;
(
    input  wire    clk,
    input  wire    reset_n,
    input  wire    i_en,
    output word_t  o_insn_addr,
    input  word_t  i_insn_data,
    output word_t  o_mem_addr,
    output word_t  o_mem_wdata,
    output logic   o_mem_we,
    input  word_t  i_mem_rdata,
    output logic   o_halt
);

    word_t pc;
    word_t x_val;
    word_t y_val;
    word_t z_val;
    word_t rhs;
    word_t reg_wdata;
    logic  reg_we;
    logic  exec_step;

    insn_fields_if fields ();

    insn_decode u_decode (
        .i_insn      (i_insn_data),
        .fields      (fields.producer)
    );

    reg_file u_regs (
        .clk         (clk),
        .reset_n     (reset_n),
        .fields      (fields.consumer),
        .i_pc        (pc),
        .i_we        (reg_we),
        .i_wdata     (reg_wdata),
        .o_x_val     (x_val),
        .o_y_val     (y_val),
        .o_z_val     (z_val)
    );

    exec_unit u_exec (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_step      (exec_step),
        .fields      (fields.consumer),
        .i_x_val     (x_val),
        .i_y_val     (y_val),
        .o_rhs       (rhs)
    );

    core_sequencer u_seq (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_en        (i_en),
        .fields      (fields.consumer),
        .i_rhs       (rhs),
        .i_z_val     (z_val),
        .i_mem_rdata (i_mem_rdata),
        .o_pc        (pc),
        .o_mem_addr  (o_mem_addr),
        .o_mem_wdata (o_mem_wdata),
        .o_reg_wdata (reg_wdata),
        .o_mem_we    (o_mem_we),
        .o_reg_we    (reg_we),
        .o_exec_step (exec_step),
        .o_halt      (o_halt)
    );

    assign o_insn_addr = pc;    // Fetch address is the PC in every phase

endmodule

`default_nettype wire

// File: sim/core_checker.sv
`default_nettype none
`timescale 1ns/1ps

module core_checker
    import core_pkg::*;
(
    input wire    clk,
    input wire    reset_n,
    input wire    i_en,
    input phase_t i_phase,
    input word_t  i_pc,
    input wire    i_halt,
    input wire    i_mem_we
);

    // A store happens in WRITE and closes the instruction
    assert property (@(posedge clk) disable iff (!reset_n)
            i_mem_we |=> i_phase == PH_DECODE && $past(i_phase) == PH_WRITE)
        else $error("o_mem_we high outside the WRITE phase or the phase did not wrap");

    assert property (@(posedge clk) disable iff (!reset_n) i_halt |=> $stable(i_pc))
        else $error("program counter moved while halted");

    assert property (@(posedge clk) disable iff (!reset_n) !i_en |=> $stable(i_phase))
        else $error("phase advanced while i_en was low");

    assert property (@(posedge clk) $rose(reset_n) |-> !i_mem_we)
        else $error("o_mem_we high in the first cycle after reset");

endmodule

bind core_sequencer core_checker u_checker (
    .clk      (clk),
    .reset_n  (reset_n),
    .i_en     (i_en),
    .i_phase  (phase_q),
    .i_pc     (pc_q),
    .i_halt   (halt_q),
    .i_mem_we (o_mem_we)
);

`default_nettype wire

// File: sim/core_tb.sv
`default_nettype none
`timescale 1ns/1ps

module core_tb
    import core_pkg::*;
();

    localparam int CODE_LEN = 96;   // Code below, illegal words up to 127, data above

    logic     clk;
    logic     reset_n;
    logic     i_en;
    logic     restore_mem;
    logic     halt;
    logic     mem_we;
    word_t    insn_addr, mem_addr, mem_wdata;
    word_t    mem [0:255] = '{default: '0};
    word_t    image [0:255];
    word_t    first_mem [0:255];
    word_t    m_mem [0:255];
    word_t    m_regs [0:15];
    word_t    m_pc;
    logic     m_halted;
    phase_t   ph;
    logic     e_illegal, e_store, e_reg_we;
    word_t    e_addr, e_data, e_wb, e_next_pc;
    reg_idx_t e_z;
    int       errors = 0, checks = 0, timeouts = 0, retired = 0;
    int       run_cycles = 0, stall_cycles = 0;

    core_top dut (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_en        (i_en),
        .o_insn_addr (insn_addr),
        .i_insn_data (mem[insn_addr[7:0]]),
        .o_mem_addr  (mem_addr),
        .o_mem_wdata (mem_wdata),
        .o_mem_we    (mem_we),
        .i_mem_rdata (mem[mem_addr[7:0]]),
        .o_halt      (halt)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (restore_mem)
            mem <= image;   // Fresh program image during reset
        else if (mem_we)
            mem[mem_addr[7:0]] <= mem_wdata;
    end

    task automatic compare_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, got %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, got %h at %0t", name, exp, act, $time);
        end
    endtask

    function automatic word_t encode(input logic kind, input logic [1:0] deref,
            input reg_idx_t z, input reg_idx_t x, input reg_idx_t y, input op_t op,
            input logic [11:0] imm);
        return {1'b0, kind, deref, z, x, y, op, imm};
    endfunction

    function automatic word_t random_insn();
        word_t       r;
        word_t       s;
        logic [11:0] data_addr;
        r = $urandom();
        s = $urandom();
        data_addr = {5'b00001, s[6:0]};     // 0x80 to 0xFF
        case (r[31:28])
            4'd7, 4'd8:     // Load into r1..r13
                return encode(1'b0, 2'b01, 4'(1 + s[15:8] % 13), 4'd0, 4'd0, OP_OR, data_addr);
            4'd9, 4'd10:    // Store any Z, r0 and r15 included
                return encode(1'b0, 2'b11, s[11:8], 4'd0, 4'd0, OP_OR, data_addr);
            4'd11, 4'd12:   // Store rhs at the r14 pointer
                return encode(r[0], 2'b10, 4'd14, r[7:4], r[11:8], op_t'(r[15:12]), r[27:16]);
            4'd13:
                return encode(1'b0, 2'b00, 4'd14, 4'd0, 4'd0, OP_OR, data_addr);
            4'd14:          // Forward jump over up to three words
                return encode(1'b0, 2'b00, 4'd15, 4'd15, 4'd0, OP_ADD, 12'(s[1:0]));
            default:
                return encode(r[0], 2'b00, 4'(1 + s[15:8] % 13), r[7:4], r[11:8],
                              op_t'(r[15:12]), r[27:16]);
        endcase
    endfunction

    function automatic word_t model_read(input reg_idx_t idx);
        if (idx == 4'd0)
            return 32'd0;
        return (idx == PC_INDEX) ? m_pc + 32'd1 : m_regs[idx];
    endfunction

    function automatic word_t apply_op(input op_t op, input word_t a, input word_t b);
        case (op)
            OP_OR:   return a | b;
            OP_AND:  return a & b;
            OP_ADD:  return a + b;
            OP_MUL:  return a * b;
            OP_SHL:  return (b > 32'd31) ? 32'd0 : a << b[4:0];
            OP_LT:   return ($signed(a) < $signed(b)) ? 32'hFFFF_FFFF : 32'd0;
            OP_EQ:   return (a == b) ? 32'hFFFF_FFFF : 32'd0;
            OP_GT:   return ($signed(a) > $signed(b)) ? 32'hFFFF_FFFF : 32'd0;
            OP_ANDN: return a & ~b;
            OP_XOR:  return a ^ b;
            OP_SUB:  return a - b;
            OP_XNOR: return ~(a ^ b);
            OP_SHR:  return (b > 32'd31) ? 32'd0 : a >> b[4:0];
            OP_NE:   return (a != b) ? 32'hFFFF_FFFF : 32'd0;
            default: return 32'd0;      // Reserved, addend only
        endcase
    endfunction

    // Effects of the instruction at the model PC, held until its WRITE edge
    task automatic model_eval();
        word_t insn;
        word_t imm_ext;
        word_t opnd;
        word_t addend;
        word_t rhs;
        insn      = m_mem[m_pc[7:0]];
        e_illegal = (insn == ILLEGAL_INSN);
        e_z       = insn[27:24];
        imm_ext   = {{20{insn[11]}}, insn[11:0]};
        opnd      = insn[30] ? imm_ext : model_read(insn[19:16]);
        addend    = insn[30] ? model_read(insn[19:16]) : imm_ext;
        rhs       = apply_op(op_t'(insn[15:12]), model_read(insn[23:20]), opnd) + addend;
        e_reg_we  = !insn[29];
        e_store   = insn[29] && !e_illegal;
        e_wb      = (insn[29:28] == 2'b01) ? m_mem[rhs[7:0]] : rhs;
        e_addr    = (insn[29:28] == 2'b10) ? model_read(e_z) : rhs;
        e_data    = (insn[29:28] == 2'b10) ? rhs : model_read(e_z);
        e_next_pc = (e_reg_we && e_z == PC_INDEX) ? e_wb : m_pc + 32'd1;
    endtask

    task automatic model_commit();
        if (e_reg_we && e_z != 4'd0 && e_z != PC_INDEX)
            m_regs[e_z] = e_wb;
        if (e_store)
            m_mem[e_addr[7:0]] = e_data;
        m_pc = e_next_pc;
        retired++;
    endtask

    task automatic check_cycle();
        model_eval();
        compare_word("o_insn_addr", m_pc, insn_addr);
        compare_bit("o_halt", m_halted, halt);
        if (!m_halted && i_en && ph == PH_WRITE) begin
            compare_bit("o_mem_we", e_store, mem_we);
            if (e_store && mem_we) begin
                compare_word("o_mem_addr", e_addr, mem_addr);
                compare_word("o_mem_wdata", e_data, mem_wdata);
            end
        end else begin
            compare_bit("o_mem_we", 1'b0, mem_we);
        end
        if (i_en && !m_halted) begin
            case (ph)
                PH_DECODE: begin
                    if (e_illegal)
                        m_halted = 1'b1;
                    else
                        ph = PH_EXEC;
                end
                PH_EXEC: ph = PH_WRITE;
                default: begin
                    model_commit();
                    ph = PH_DECODE;
                end
            endcase
        end
    endtask

    task automatic apply_reset();
        reset_n     = 1'b0;
        restore_mem = 1'b1;
        repeat (16) @(posedge clk);
        #2;
        reset_n     = 1'b1;
        restore_mem = 1'b0;
        m_mem       = image;
        m_regs      = '{default: '0};
        m_pc        = RESET_VECTOR;
        m_halted    = 1'b0;
        ph          = PH_DECODE;
    endtask

    task automatic run_program(input bit with_stalls);
        int post_halt;
        int stall_left;
        post_halt  = 0;
        stall_left = 0;
        apply_reset();
        run_cycles   = 0;
        stall_cycles = 0;
        // First pass sees the reset state, last passes the frozen halt
        while (post_halt < 12) begin
            if (with_stalls && stall_left == 0 && $urandom() % 5 == 0)
                stall_left = 1 + int'($urandom() % 4);
            i_en = (stall_left == 0);
            if (stall_left > 0) begin
                stall_left--;
                stall_cycles++;
            end
            @(negedge clk);
            check_cycle();
            if (m_halted)
                post_halt++;
            run_cycles++;
            @(posedge clk);
            #2;
        end
    endtask

    task automatic print_summary();
        $display("Checks %0d, value errors %0d, timeouts %0d, instructions retired %0d",
                 checks, errors, timeouts, retired);
    endtask

    initial begin
        wait (run_cycles > 3 * CODE_LEN + stall_cycles + 100);
        timeouts++;
        $display("Timeout: the core did not halt within %0d cycles", run_cycles);
        print_summary();
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        reset_n     = 1'b0;
        i_en        = 1'b0;
        restore_mem = 1'b1;
        void'($urandom(16846));
        image[0] = encode(1'b0, 2'b00, 4'd14, 4'd0, 4'd0, OP_OR, 12'h0C0);   // Data pointer
        for (int a = 1; a < 256; a++)
            image[8'(a)] = (a < CODE_LEN - 1) ? random_insn()
                         : ((a < 128) ? ILLEGAL_INSN : $urandom());
        run_program(1'b0);
        first_mem = mem;
        run_program(1'b1);
        // Stalls leave the same memory behind
        for (int a = 0; a < 256; a++)
            compare_word($sformatf("mem[%0d]", a), first_mem[8'(a)], mem[8'(a)]);
        print_summary();
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tiny_core.f
verilog/core_pkg.sv
verilog/insn_fields_if.sv
verilog/insn_decode.sv
verilog/reg_file.sv
verilog/exec_unit.sv
verilog/core_sequencer.sv
verilog/core_top.sv
sim/core_checker.sv
sim/core_tb.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := core_tb
FILELIST  := tiny_core.f
BUILD     := obj_dir
LOG       := sim.log
PASS_MSG  := Result: PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
